//--- design/fpdiv_pkg.sv
// -------------------------------------------------------------------------
// shared widths, constants and enums for the binary32 radix-16 divider
// imported by every RTL module and the quotient interface
// -------------------------------------------------------------------------
`default_nettype none

package fpdiv_pkg;

  // binary32 fields
  parameter int EXP_W   = 8;
  parameter int MAN_W   = 23;
  parameter int SIG_W   = MAN_W + 1;
  parameter int BIAS    = 127;
  parameter int EXP_MAX = 255;

  // one 0/1 digit then seven radix-16 digits
  parameter int N_ITER = 8;
  parameter int QUOT_W = 29;
  // significand, four shift bits, one guard bit
  parameter int REM_W  = SIG_W + 5;
  // signed, room for overflow and underflow
  parameter int EXPD_W = 10;

  typedef enum logic [2:0] {
    RM_TRUNC = 3'd0,
    RM_ROUND = 3'd1,
    RM_EVEN  = 3'd2,
    RM_PLUS  = 3'd3,
    RM_MINUS = 3'd4
  } rmode_e;

  // rounding action once mode and sign are known
  typedef enum logic [1:0] {
    RA_NONE,
    RA_HALF,
    RA_EVEN,
    RA_ANY
  } rnd_act_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ITER,
    ST_ROUND,
    ST_HOLD
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- design/quot_if.sv
// -------------------------------------------------------------------------
// raw quotient plus exponent and sign data handed to the rounder
// -------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

interface quot_if import fpdiv_pkg::*; ();

  logic [QUOT_W-1:0]        digits;
  logic                     sticky;
  logic signed [EXPD_W-1:0] exp_pre;
  logic                     sign;
  rnd_act_e                 act;

  modport dsel (output digits, output sticky);
  modport esu  (output exp_pre, output sign, output act);
  modport rnd  (input digits, input sticky, input exp_pre, input sign, input act);

endinterface

`default_nettype wire

//--- design/fpdiv_ctrl.sv
// -------------------------------------------------------------------------
// sequencer for one division: load, eight iterations, round, hold result
// drives the datapath strobes and both handshakes
// -------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module fpdiv_ctrl import fpdiv_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic start,
  input  logic out_ready,
  output logic ready,
  output logic out_valid,
  output logic load,
  output logic iterate,
  output logic round_en
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic [2:0]  cnt_q;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: begin
        if (start) begin
          state_d = ST_ITER;
        end
      end
      ST_ITER: begin
        // last digit
        if (cnt_q == 3'(N_ITER - 1)) begin
          state_d = ST_ROUND;
        end
      end
      ST_ROUND: state_d = ST_HOLD;
      ST_HOLD: begin
        if (out_ready) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      // wraps back to zero on the last step
      cnt_q   <= iterate ? cnt_q + 3'd1 : 3'd0;
    end
  end

  assign ready     = (state_q == ST_IDLE);
  assign out_valid = (state_q == ST_HOLD);
  assign load      = ready & start;
  assign iterate   = (state_q == ST_ITER);
  assign round_en  = (state_q == ST_ROUND);

endmodule

`default_nettype wire

//--- design/divisor_multiples.sv
// -------------------------------------------------------------------------
// table of 1..15 times the divisor significand, captured at load
// -------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module divisor_multiples import fpdiv_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    load,
  input  logic [SIG_W-1:0]        b_sig,
  output logic [15:1][SIG_W+3:0]  mult
);

  logic [SIG_W+3:0] b1, b3, b5, b7, b9, b11, b13, b15;
  logic [15:1][SIG_W+3:0] mult_d;

  // odd multiples by shifted adds
  assign b1  = {4'b0, b_sig};
  assign b3  = b1 + (b1 << 1);
  assign b5  = b1 + (b1 << 2);
  assign b7  = b3 + (b1 << 2);
  assign b9  = b1 + (b1 << 3);
  assign b11 = b3 + (b1 << 3);
  assign b13 = b5 + (b1 << 3);
  assign b15 = b7 + (b1 << 3);

  // evens are shifts of the odd ones
  assign mult_d = {b15, b7 << 1, b13, b3 << 2, b11, b5 << 1, b9, b1 << 3,
                   b7, b3 << 1, b5, b1 << 2, b3, b1 << 1, b1};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mult <= '0;
    end else if (load) begin
      mult <= mult_d;
    end
  end

endmodule

`default_nettype wire

//--- design/digit_select.sv
// -------------------------------------------------------------------------
// radix-16 digit recurrence: partial remainder, parallel compare against
// the divisor multiples, digit pick and quotient shift register
// -------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module digit_select import fpdiv_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   load,
  input  logic                   iterate,
  input  logic [SIG_W-1:0]       a_sig,
  input  logic [15:1][SIG_W+3:0] mult,
  quot_if.dsel                   qi
);

  logic [REM_W-1:0]  rem_q;
  logic [REM_W-1:0]  rem_s;
  logic [REM_W-1:0]  rem_d;
  logic [REM_W-1:0]  sub;
  logic [QUOT_W-1:0] digits_q;
  logic              first_q;
  logic [15:1]       ge;
  logic [15:1]       sel;
  logic [3:0]        digit;

  // no scaling on the first step, digit is only 0 or 1 there
  assign rem_s = first_q ? rem_q : {rem_q[REM_W-5:0], 4'b0};

  always_comb begin
    for (int i = 1; i <= 15; i++) begin
      ge[i] = (rem_s >= {1'b0, mult[i]});
    end
    if (first_q) begin
      ge[15:2] = '0;
    end
  end

  // thermometer to one-hot
  always_comb begin
    for (int i = 1; i < 15; i++) begin
      sel[i] = ge[i] & ~ge[i+1];
    end
    sel[15] = ge[15];
  end

  always_comb begin
    digit = '0;
    sub   = '0;
    for (int i = 1; i <= 15; i++) begin
      if (sel[i]) begin
        digit = digit | 4'(i);
        sub   = sub | {1'b0, mult[i]};
      end
    end
  end

  assign rem_d = rem_s - sub;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rem_q    <= '0;
      digits_q <= '0;
      first_q  <= 1'b0;
    end else if (load) begin
      rem_q    <= REM_W'(a_sig);
      digits_q <= '0;
      first_q  <= 1'b1;
    end else if (iterate) begin
      rem_q    <= rem_d;
      // upper zeros of the first digit fall off the top
      digits_q <= {digits_q[QUOT_W-5:0], digit};
      first_q  <= 1'b0;
    end
  end

  assign qi.digits = digits_q;
  assign qi.sticky = |rem_q;

endmodule

`default_nettype wire

//--- design/exp_sign_unit.sv
// -------------------------------------------------------------------------
// result sign, biased exponent difference and rounding action at load
// -------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module exp_sign_unit import fpdiv_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             load,
  input  logic [EXP_W-1:0] a_exp,
  input  logic [EXP_W-1:0] b_exp,
  input  logic             a_sign,
  input  logic             b_sign,
  input  rmode_e           rmode,
  quot_if.esu              qi
);

  logic                     sign_d;
  logic signed [EXPD_W-1:0] exp_d;
  rnd_act_e                 act_d;

  assign sign_d = a_sign ^ b_sign;
  assign exp_d  = $signed(EXPD_W'(a_exp)) - $signed(EXPD_W'(b_exp))
                + $signed(EXPD_W'(BIAS));

  // directed modes only round away from zero on their own side
  always_comb begin
    unique case (rmode)
      RM_TRUNC: act_d = RA_NONE;
      RM_ROUND: act_d = RA_HALF;
      RM_EVEN:  act_d = RA_EVEN;
      RM_PLUS:  act_d = sign_d ? RA_NONE : RA_ANY;
      RM_MINUS: act_d = sign_d ? RA_ANY : RA_NONE;
      default:  act_d = RA_NONE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      qi.sign    <= 1'b0;
      qi.exp_pre <= '0;
      qi.act     <= RA_NONE;
    end else if (load) begin
      qi.sign    <= sign_d;
      qi.exp_pre <= exp_d;
      qi.act     <= act_d;
    end
  end

endmodule

`default_nettype wire

//--- design/quot_round.sv
// -------------------------------------------------------------------------
// normalize and round the raw quotient, saturate the exponent, pack binary32
// result and tag stay registered until the next operation
// -------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module quot_round import fpdiv_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        round_en,
  input  logic        load,
  input  logic [7:0]  tag_in,
  quot_if.rnd         qi,
  output logic [31:0] result,
  output logic [7:0]  result_tag
);

  logic                     lead;
  logic [SIG_W-1:0]         sig;
  logic                     rbit;
  logic                     stk;
  logic                     inc;
  logic [SIG_W:0]           sum;
  logic signed [EXPD_W-1:0] exp_n;
  logic signed [EXPD_W-1:0] exp_f;
  logic [31:0]              result_d;

  // quotient lies in (2^27, 2^29)
  assign lead  = qi.digits[QUOT_W-1];
  assign sig   = lead ? qi.digits[28:5] : qi.digits[27:4];
  assign rbit  = lead ? qi.digits[4] : qi.digits[3];
  assign stk   = qi.sticky | (lead ? |qi.digits[3:0] : |qi.digits[2:0]);
  assign exp_n = lead ? qi.exp_pre : qi.exp_pre - EXPD_W'(1);

  always_comb begin
    unique case (qi.act)
      RA_HALF: inc = rbit;
      RA_EVEN: inc = rbit & (stk | sig[0]);
      RA_ANY:  inc = rbit | stk;
      default: inc = 1'b0;
    endcase
  end

  assign sum = {1'b0, sig} + (SIG_W + 1)'(inc);
  // carry out leaves a zero fraction one binade up
  assign exp_f = sum[SIG_W] ? exp_n + EXPD_W'(1) : exp_n;

  always_comb begin
    if (exp_f >= EXPD_W'(EXP_MAX)) begin
      result_d = {qi.sign, {EXP_W{1'b1}}, {MAN_W{1'b0}}};
    end else if (exp_f <= EXPD_W'(0)) begin
      result_d = {qi.sign, {(EXP_W + MAN_W){1'b0}}};
    end else begin
      result_d = {qi.sign, exp_f[EXP_W-1:0], sum[MAN_W-1:0]};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result     <= '0;
      result_tag <= '0;
    end else begin
      if (load) begin
        result_tag <= tag_in;
      end
      if (round_en) begin
        result <= result_d;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/fpdiv_top.sv
// -------------------------------------------------------------------------
// binary32 divider, one operation in flight, fixed nine-cycle latency
// start/ready on the input side, out_valid/out_ready on the result side
// -------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module fpdiv_top import fpdiv_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start,
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  logic [2:0]  rmode,
  input  logic [7:0]  tag,
  input  logic        out_ready,
  output logic        ready,
  output logic [31:0] result,
  output logic [7:0]  result_tag,
  output logic        out_valid
);

  logic                   load;
  logic                   iterate;
  logic                   round_en;
  logic [SIG_W-1:0]       a_sig;
  logic [SIG_W-1:0]       b_sig;
  logic [15:1][SIG_W+3:0] mult;

  quot_if qi ();

  // hidden one restored, inputs assumed normal
  assign a_sig = {1'b1, a[MAN_W-1:0]};
  assign b_sig = {1'b1, b[MAN_W-1:0]};

  fpdiv_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .out_ready (out_ready),
    .ready     (ready),
    .out_valid (out_valid),
    .load      (load),
    .iterate   (iterate),
    .round_en  (round_en)
  );

  divisor_multiples u_mult (
    .clk   (clk),
    .rst_n (rst_n),
    .load  (load),
    .b_sig (b_sig),
    .mult  (mult)
  );

  digit_select u_dsel (
    .clk     (clk),
    .rst_n   (rst_n),
    .load    (load),
    .iterate (iterate),
    .a_sig   (a_sig),
    .mult    (mult),
    .qi      (qi.dsel)
  );

  exp_sign_unit u_esu (
    .clk    (clk),
    .rst_n  (rst_n),
    .load   (load),
    .a_exp  (a[EXP_W+MAN_W-1:MAN_W]),
    .b_exp  (b[EXP_W+MAN_W-1:MAN_W]),
    .a_sign (a[31]),
    .b_sign (b[31]),
    .rmode  (rmode_e'(rmode)),
    .qi     (qi.esu)
  );

  quot_round u_rnd (
    .clk        (clk),
    .rst_n      (rst_n),
    .round_en   (round_en),
    .load       (load),
    .tag_in     (tag),
    .qi         (qi.rnd),
    .result     (result),
    .result_tag (result_tag)
  );

endmodule

`default_nettype wire

//--- verif/fpdiv_props.sv
// --------------------------------------------------------------------------
// handshake and latency assertions, bound into the divider top level
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module fpdiv_props (
  input logic        clk,
  input logic        rst_n,
  input logic        start,
  input logic        ready,
  input logic        out_valid,
  input logic        out_ready,
  input logic [31:0] result,
  input logic [7:0]  result_tag
);

  // idle and hold never overlap
  excl_chk: assert property (@(posedge clk) disable iff (!rst_n) !(ready && out_valid))
    else $error("ready and out_valid high together");

  hold_chk: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(result) && $stable(result_tag)))
    else $error("result changed while held");

  // accepted at E0, out_valid high after E9
  lat_chk: assert property (@(posedge clk) disable iff (!rst_n)
    (start && ready) |-> ##10 $rose(out_valid))
    else $error("out_valid not raised nine cycles after accept");

endmodule

bind fpdiv_top fpdiv_props u_props (
  .clk        (clk),
  .rst_n      (rst_n),
  .start      (start),
  .ready      (ready),
  .out_valid  (out_valid),
  .out_ready  (out_ready),
  .result     (result),
  .result_tag (result_tag)
);

`default_nettype wire

//--- verif/tb_fpdiv.sv
// --------------------------------------------------------------------------
// testbench for the binary32 divider: directed and random divisions in all
// five rounding modes, random back-pressure, results checked in order
// --------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_fpdiv import fpdiv_pkg::*;;

  localparam int          DRIVE_DLY  = 10;
  localparam int          WAIT_LIMIT = 200;
  localparam int          N_RAND     = 250;
  localparam logic [31:0] SEED       = 32'hebb5_e926;

  logic        clk;
  logic        rst_n;
  logic        start;
  logic [31:0] a;
  logic [31:0] b;
  logic [2:0]  rmode;
  logic [7:0]  tag;
  logic        out_ready;
  logic        ready;
  logic [31:0] result;
  logic [7:0]  result_tag;
  logic        out_valid;

  logic [31:0] exp_q[$];
  logic [7:0]  tag_q[$];
  logic [31:0] op_rng;
  logic [31:0] bp_rng;
  logic [7:0]  next_tag;
  int          n_checks;
  int          n_errors;

  fpdiv_top DUT (.*);

  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // normal operand, exponent 100..154 so random quotients stay normal
  function automatic logic [31:0] rand_operand();
    logic [31:0] r1;
    logic [31:0] r2;
    op_rng = xorshift32(op_rng);
    r1     = op_rng;
    op_rng = xorshift32(op_rng);
    r2     = op_rng;
    return {r1[31], 8'd100 + 8'(r2 % 32'd55), r1[22:0]};
  endfunction

  // expected quotient from floor(A * 2^28 / B) and the rounding rules
  function automatic logic [31:0] ref_div(input logic [31:0] x, input logic [31:0] y,
                                          input logic [2:0] rm);
    logic [63:0] num;
    logic [63:0] den;
    logic [63:0] q;
    logic [63:0] r;
    logic [63:0] m;
    logic [23:0] sig;
    logic        s;
    logic        rb;
    logic        st;
    logic        up;
    int          e;
    num = 64'({1'b1, x[22:0]}) << 28;
    den = 64'({1'b1, y[22:0]});
    q   = num / den;
    r   = num % den;
    s   = x[31] ^ y[31];
    e   = int'(x[30:23]) - int'(y[30:23]) + 127;
    if (q[28]) begin
      sig = q[28:5];
      rb  = q[4];
      st  = (|r) | (|q[3:0]);
    end else begin
      sig = q[27:4];
      rb  = q[3];
      st  = (|r) | (|q[2:0]);
      e   = e - 1;
    end
    case (rm)
      RM_ROUND: up = rb;
      RM_EVEN:  up = rb & (st | sig[0]);
      RM_PLUS:  up = ~s & (rb | st);
      RM_MINUS: up = s & (rb | st);
      default:  up = 1'b0;
    endcase
    m = 64'(sig) + 64'(up);
    if (m[24]) begin
      e = e + 1;
    end
    if (e >= 255) begin
      return {s, 8'hff, 23'd0};
    end else if (e <= 0) begin
      return {s, 31'd0};
    end else begin
      return {s, e[7:0], m[22:0]};
    end
  endfunction

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] want);
    n_checks++;
    if (got !== want) begin
      n_errors++;
      $display("** Error at %0d ns: %s is %h, expected %h", $time, name, got, want);
    end
  endtask

  task automatic abort_run(input string why);
    n_errors++;
    $display("** Error at %0d ns: %s", $time, why);
    $display("checks %0d, errors %0d", n_checks, n_errors);
    $display("** FAIL **");
    $finish;
  endtask

  task automatic issue_op(input logic [31:0] op_a, input logic [31:0] op_b,
                          input int rm, input logic [31:0] want);
    int waited;
    waited = 0;
    while (!ready && waited < WAIT_LIMIT) begin
      @(posedge clk);
      #DRIVE_DLY;
      waited++;
    end
    if (!ready) begin
      abort_run("ready stayed low, the DUT never came back to idle");
    end else begin
      start = 1'b1;
      a     = op_a;
      b     = op_b;
      rmode = 3'(rm);
      tag   = next_tag;
      exp_q.push_back(want);
      tag_q.push_back(next_tag);
      next_tag = next_tag + 8'd1;
      @(posedge clk);
      #DRIVE_DLY;
      start = 1'b0;
      // a start while busy must not produce a result
      op_rng = xorshift32(op_rng);
      if (op_rng[0]) begin
        start = 1'b1;
        a     = op_rng;
        b     = ~op_rng;
        tag   = 8'hee;
        @(posedge clk);
        #DRIVE_DLY;
        start = 1'b0;
      end
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
      @(posedge clk);
      #DRIVE_DLY;
      waited++;
    end
    if (exp_q.size() != 0) begin
      abort_run("results still outstanding after the last operation");
    end
  endtask

  // random back-pressure, low about three cycles in eight
  initial begin
    out_ready = 1'b0;
    bp_rng    = {SEED[15:0], SEED[31:16]};
    forever begin
      @(posedge clk);
      #DRIVE_DLY;
      bp_rng    = xorshift32(bp_rng);
      out_ready = (bp_rng[2:0] > 3'd2);
    end
  end

  // takes every output handshake in order, checks held values meanwhile
  initial begin
    logic [31:0] held_res;
    logic [7:0]  held_tag;
    logic        held;
    logic [31:0] want;
    logic [7:0]  want_tag;
    held = 1'b0;
    forever begin
      @(negedge clk);
      if (rst_n && out_valid) begin
        if (held) begin
          check_val("result", result, held_res);
          check_val("result_tag", 32'(result_tag), 32'(held_tag));
        end
        if (out_ready) begin
          if (exp_q.size() == 0) begin
            n_errors++;
            $display("** Error at %0d ns: result handed over with no operation pending",
                     $time);
          end else begin
            want     = exp_q.pop_front();
            want_tag = tag_q.pop_front();
            check_val("result", result, want);
            check_val("result_tag", 32'(result_tag), 32'(want_tag));
          end
          held = 1'b0;
        end else begin
          held     = 1'b1;
          held_res = result;
          held_tag = result_tag;
        end
      end else begin
        held = 1'b0;
      end
    end
  end

  initial begin
    logic [31:0] x;
    logic [31:0] y;
    clk      = 1'b0;
    rst_n    = 1'b0;
    start    = 1'b0;
    a        = '0;
    b        = '0;
    rmode    = '0;
    tag      = '0;
    op_rng   = SEED;
    next_tag = 8'd0;
    n_checks = 0;
    n_errors = 0;
    repeat (4) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    check_val("ready", 32'(ready), 32'd1);
    check_val("out_valid", 32'(out_valid), 32'd0);

    // exact quotients, no mode may change them
    for (int m = 0; m < 5; m++) begin
      issue_op(32'h40c0_0000, 32'h4040_0000, m, 32'h4000_0000);
      issue_op(32'h3f80_0000, 32'h4080_0000, m, 32'h3e80_0000);
      issue_op(32'hc0f0_0000, 32'h4020_0000, m, 32'hc040_0000);
    end

    // 1/3 and -1/3, directed modes round away only on their own side
    issue_op(32'h3f80_0000, 32'h4040_0000, RM_PLUS, 32'h3eaa_aaab);
    issue_op(32'h3f80_0000, 32'h4040_0000, RM_MINUS, 32'h3eaa_aaaa);
    issue_op(32'hbf80_0000, 32'h4040_0000, RM_PLUS, 32'hbeaa_aaaa);
    issue_op(32'hbf80_0000, 32'h4040_0000, RM_MINUS, 32'hbeaa_aaab);
    issue_op(32'h3f80_0000, 32'h4040_0000, RM_TRUNC, 32'h3eaa_aaaa);
    issue_op(32'h3f80_0000, 32'h4040_0000, RM_ROUND, 32'h3eaa_aaab);
    issue_op(32'h3f80_0000, 32'h4040_0000, RM_EVEN, 32'h3eaa_aaab);
    // no quotient is an exact tie, so just above half an ulp both modes
    // round up and the only sticky bit comes from the remainder
    issue_op(32'h3fff_ffff, 32'h3fff_fffe, RM_TRUNC, 32'h3f80_0000);
    issue_op(32'h3fff_ffff, 32'h3fff_fffe, RM_ROUND, 32'h3f80_0001);
    issue_op(32'h3fff_ffff, 32'h3fff_fffe, RM_EVEN, 32'h3f80_0001);

    // exponent saturation
    for (int m = 0; m < 5; m++) begin
      issue_op(32'h7d00_0000, 32'h0500_0000, m, 32'h7f80_0000);
      issue_op(32'hfd00_0000, 32'h0500_0000, m, 32'hff80_0000);
      issue_op(32'h0500_0000, 32'h7d00_0000, m, 32'h0000_0000);
      issue_op(32'h0500_0000, 32'hfd00_0000, m, 32'h8000_0000);
    end

    for (int i = 0; i < N_RAND; i++) begin
      x = rand_operand();
      y = rand_operand();
      issue_op(x, y, i % 5, ref_div(x, y, 3'(i % 5)));
    end

    wait_drain();
    repeat (20) @(posedge clk);
    #DRIVE_DLY;
    check_val("out_valid", 32'(out_valid), 32'd0);
    check_val("ready", 32'(ready), 32'd1);

    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
design/fpdiv_pkg.sv
design/quot_if.sv
design/fpdiv_ctrl.sv
design/divisor_multiples.sv
design/digit_select.sv
design/exp_sign_unit.sv
design/quot_round.sv
design/fpdiv_top.sv
verif/fpdiv_props.sv
verif/tb_fpdiv.sv

//--- run.sh
#!/bin/sh
# build the divider testbench with Verilator, run it, judge from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_fpdiv --Mdir obj_dir -f list.f \
  && ./obj_dir/Vtb_fpdiv > sim.log 2>&1

cat sim.log 2>/dev/null

grep -qxF '** PASS **' sim.log 2>/dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
